// ==== design/core_pkg.sv ====
`default_nettype none

package core_pkg;

    localparam int XLEN          = 32;
    localparam int NR_REGS       = 16;
    localparam int REG_BITS      = 4;
    localparam int NR_LANES      = 2;
    localparam int NR_SB_ENTRIES = 4;
    localparam int TRANS_ID_BITS = 2;
    localparam int MUL_CYCLES    = 4;
    localparam int MUL_SLICE     = 8;     // bits of b consumed per multiply step

    // instruction word layout
    localparam int OPC_BITS = 4;
    localparam int IMM_BITS = 16;
    localparam int OPC_LSB  = 28;
    localparam int RD_LSB   = 24;
    localparam int RS1_LSB  = 20;
    localparam int RS2_LSB  = 16;

    // codes 8..15 retire as no-ops
    typedef enum logic [OPC_BITS-1:0] {
        OP_ADD  = 4'h0,
        OP_SUB  = 4'h1,
        OP_AND  = 4'h2,
        OP_OR   = 4'h3,
        OP_XOR  = 4'h4,
        OP_ADDI = 4'h5,
        OP_MUL  = 4'h6,
        OP_HALT = 4'h7
    } op_e;

endpackage

`default_nettype wire

// ==== design/fetch_unit.sv ====
`default_nettype none

module fetch_unit (
    input  logic                      clk_i,
    input  logic                      rst_n,
    input  logic                      enable_i,
    input  logic [core_pkg::XLEN-1:0] boot_addr_i,
    input  logic                      halt_i,
    output logic                      wb_cyc_o,
    output logic                      wb_stb_o,
    output logic [core_pkg::XLEN-1:0] wb_adr_o,
    input  logic [core_pkg::XLEN-1:0] wb_dat_i,
    input  logic                      wb_ack_i,
    output logic                      instr_valid_o,
    output logic [core_pkg::XLEN-1:0] instr_data_o,
    input  logic                      instr_ready_i
);
    import core_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE,
        S_REQ,     // bus cycle open
        S_HOLD,    // word buffered, waiting for issue
        S_STOP
    } state_e;

    state_e          state_q;
    state_e          state_d;
    logic [XLEN-1:0] pc_q;
    logic [XLEN-1:0] buf_q;

    assign wb_cyc_o      = (state_q == S_REQ);
    assign wb_stb_o      = (state_q == S_REQ);
    assign wb_adr_o      = pc_q;
    assign instr_valid_o = (state_q == S_HOLD);
    assign instr_data_o  = buf_q;

    always_comb begin
        state_d = state_q;
        case (state_q)
            S_IDLE: begin
                if (enable_i) begin
                    state_d = S_REQ;
                end
            end
            S_REQ: begin
                if (wb_ack_i) begin
                    state_d = halt_i ? S_STOP : S_HOLD;  // word after halt is dropped
                end
            end
            S_HOLD: begin
                if (halt_i) begin
                    state_d = S_STOP;
                end else if (instr_ready_i) begin
                    state_d = S_REQ;
                end
            end
            default: state_d = S_STOP;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= S_IDLE;
            pc_q    <= '0;
        end else begin
            state_q <= state_d;
            if (state_q == S_IDLE && enable_i) begin
                pc_q <= boot_addr_i;
            end else if (state_q == S_REQ && wb_ack_i) begin
                pc_q <= pc_q + XLEN'(1);   // word address
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == S_REQ && wb_ack_i) begin
            buf_q <= wb_dat_i;
        end
    end

endmodule

`default_nettype wire

// ==== design/issue_stage.sv ====
`default_nettype none

module issue_stage (
    input  logic                                                       clk_i,
    input  logic                                                       rst_n,
    input  logic                                                       instr_valid_i,
    input  logic [core_pkg::XLEN-1:0]                                  instr_data_i,
    output logic                                                       instr_ready_o,
    output logic                                                       halt_o,
    output logic [core_pkg::REG_BITS-1:0]                              raddr_a_o,
    output logic [core_pkg::REG_BITS-1:0]                              raddr_b_o,
    input  logic [core_pkg::XLEN-1:0]                                  rdata_a_i,
    input  logic [core_pkg::XLEN-1:0]                                  rdata_b_i,
    output logic [core_pkg::NR_LANES-1:0]                              lane_valid_o,
    output core_pkg::op_e [core_pkg::NR_LANES-1:0]                     lane_op_o,
    output logic [core_pkg::NR_LANES-1:0][core_pkg::XLEN-1:0]          lane_a_o,
    output logic [core_pkg::NR_LANES-1:0][core_pkg::XLEN-1:0]          lane_b_o,
    output logic [core_pkg::NR_LANES-1:0][core_pkg::TRANS_ID_BITS-1:0] lane_id_o,
    input  logic [core_pkg::NR_LANES-1:0]                              lane_ready_i,
    input  logic [core_pkg::NR_LANES-1:0]                              lane_done_i,
    input  logic [core_pkg::NR_LANES-1:0][core_pkg::XLEN-1:0]          lane_result_i,
    input  logic [core_pkg::NR_LANES-1:0][core_pkg::TRANS_ID_BITS-1:0] lane_done_id_i,
    output logic                                                       head_valid_o,
    output logic [core_pkg::REG_BITS-1:0]                              head_rd_o,
    output logic                                                       head_we_o,
    output logic [core_pkg::XLEN-1:0]                                  head_data_o,
    output logic                                                       head_halt_o,
    input  logic                                                       commit_ack_i,
    output logic                                                       busy_o
);
    import core_pkg::*;

    logic [OPC_BITS-1:0]      opcode;
    logic [REG_BITS-1:0]      rd;
    logic [REG_BITS-1:0]      rs1;
    logic [REG_BITS-1:0]      rs2;
    logic [XLEN-1:0]          imm;
    logic                     is_alu;
    logic                     is_halt;
    logic                     hazard;
    logic                     fire;
    logic [NR_LANES-1:0]      grant;

    // scoreboard, one entry per transaction id
    logic [NR_SB_ENTRIES-1:0] sb_valid_q;
    logic [NR_SB_ENTRIES-1:0] sb_done_q;
    logic [NR_SB_ENTRIES-1:0] sb_we_q;
    logic [NR_SB_ENTRIES-1:0] sb_halt_q;
    logic [REG_BITS-1:0]      sb_rd_q   [NR_SB_ENTRIES];
    logic [XLEN-1:0]          sb_data_q [NR_SB_ENTRIES];
    logic [TRANS_ID_BITS-1:0] head_q;
    logic [TRANS_ID_BITS-1:0] tail_q;
    logic                     halted_q;

    assign opcode    = instr_data_i[OPC_LSB +: OPC_BITS];
    assign rd        = instr_data_i[RD_LSB +: REG_BITS];
    assign rs1       = instr_data_i[RS1_LSB +: REG_BITS];
    assign rs2       = instr_data_i[RS2_LSB +: REG_BITS];
    assign imm       = {{(XLEN-IMM_BITS){instr_data_i[IMM_BITS-1]}}, instr_data_i[IMM_BITS-1:0]};
    assign raddr_a_o = rs1;
    assign raddr_b_o = rs2;
    assign is_halt   = (opcode == OP_HALT);

    always_comb begin
        case (opcode)
            OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_ADDI, OP_MUL: is_alu = 1'b1;
            default: is_alu = 1'b0;
        endcase
    end

    // no forwarding, so any pending writer of a source stalls issue
    always_comb begin
        hazard = 1'b0;
        for (int i = 0; i < NR_SB_ENTRIES; i++) begin
            if (sb_valid_q[i] && sb_we_q[i] && (sb_rd_q[i] == rs1 || sb_rd_q[i] == rs2)) begin
                hazard = 1'b1;
            end
        end
    end

    assign grant = lane_ready_i & ~(lane_ready_i - 1'b1);   // lowest ready lane

    // tail entry still valid means the scoreboard is full
    assign instr_ready_o = !halted_q && !sb_valid_q[tail_q] && !hazard
                           && (!is_alu || |lane_ready_i);
    assign fire          = instr_valid_i && instr_ready_o;
    assign halt_o        = halted_q || (fire && is_halt);

    always_comb begin
        for (int k = 0; k < NR_LANES; k++) begin
            lane_valid_o[k] = fire && is_alu && grant[k];
            lane_op_o[k]    = op_e'(opcode);
            lane_a_o[k]     = rdata_a_i;
            lane_b_o[k]     = (opcode == OP_ADDI) ? imm : rdata_b_i;
            lane_id_o[k]    = tail_q;
        end
    end

    assign head_valid_o = sb_valid_q[head_q] && sb_done_q[head_q];
    assign head_rd_o    = sb_rd_q[head_q];
    assign head_we_o    = sb_we_q[head_q];
    assign head_data_o  = sb_data_q[head_q];
    assign head_halt_o  = sb_halt_q[head_q];
    assign busy_o       = |sb_valid_q;

    always_ff @(posedge clk_i or negedge rst_n) begin
        if (!rst_n) begin
            sb_valid_q <= '0;
            sb_done_q  <= '0;
            head_q     <= '0;
            tail_q     <= '0;
            halted_q   <= 1'b0;
        end else begin
            for (int k = 0; k < NR_LANES; k++) begin
                if (lane_done_i[k]) begin
                    sb_done_q[lane_done_id_i[k]] <= 1'b1;
                end
            end
            if (fire) begin
                sb_valid_q[tail_q] <= 1'b1;
                sb_done_q[tail_q]  <= !is_alu;     // halt and no-ops finish at issue
                tail_q             <= tail_q + 1'b1;
                halted_q           <= halted_q || is_halt;
            end
            if (commit_ack_i) begin
                sb_valid_q[head_q] <= 1'b0;
                head_q             <= head_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (fire) begin
            sb_rd_q[tail_q]   <= rd;
            sb_we_q[tail_q]   <= is_alu;
            sb_halt_q[tail_q] <= is_halt;
            sb_data_q[tail_q] <= '0;
        end
        // completions arrive in any order
        for (int k = 0; k < NR_LANES; k++) begin
            if (lane_done_i[k]) begin
                sb_data_q[lane_done_id_i[k]] <= lane_result_i[k];
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/alu_lane.sv ====
`default_nettype none

module alu_lane (
    input  logic                               clk_i,
    input  logic                               rst_n,
    input  logic                               valid_i,
    input  core_pkg::op_e                      op_i,
    input  logic [core_pkg::XLEN-1:0]          a_i,
    input  logic [core_pkg::XLEN-1:0]          b_i,
    input  logic [core_pkg::TRANS_ID_BITS-1:0] id_i,
    output logic                               ready_o,
    output logic                               done_o,
    output logic [core_pkg::XLEN-1:0]          result_o,
    output logic [core_pkg::TRANS_ID_BITS-1:0] done_id_o
);
    import core_pkg::*;

    logic                          accept;
    logic                          mul_busy_q;
    logic [$clog2(MUL_CYCLES)-1:0] step_q;
    logic [XLEN-1:0]               mcand_q;    // a, moved up one slice per step
    logic [XLEN-1:0]               mplier_q;   // slices of b still to go
    logic [XLEN-1:0]               acc_q;
    logic [XLEN-1:0]               acc_next;
    logic [XLEN-1:0]               alu_res;

    assign ready_o  = !mul_busy_q;
    assign accept   = valid_i && ready_o;
    assign acc_next = acc_q + mcand_q * mplier_q[MUL_SLICE-1:0];

    always_comb begin
        case (op_i)
            OP_ADD, OP_ADDI: alu_res = a_i + b_i;
            OP_SUB:          alu_res = a_i - b_i;
            OP_AND:          alu_res = a_i & b_i;
            OP_OR:           alu_res = a_i | b_i;
            OP_XOR:          alu_res = a_i ^ b_i;
            default:         alu_res = '0;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n) begin
        if (!rst_n) begin
            mul_busy_q <= 1'b0;
            step_q     <= '0;
            done_o     <= 1'b0;
        end else begin
            done_o <= 1'b0;
            if (accept) begin
                mul_busy_q <= (op_i == OP_MUL);
                done_o     <= (op_i != OP_MUL);
                step_q     <= 1'b1;   // first slice taken at acceptance
            end else if (mul_busy_q) begin
                step_q <= step_q + 1'b1;
                if (step_q == MUL_CYCLES - 1) begin
                    mul_busy_q <= 1'b0;
                    done_o     <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            done_id_o <= id_i;
            result_o  <= alu_res;
            acc_q     <= a_i * b_i[MUL_SLICE-1:0];
            mcand_q   <= a_i << MUL_SLICE;
            mplier_q  <= b_i >> MUL_SLICE;
        end else if (mul_busy_q) begin
            acc_q    <= acc_next;
            mcand_q  <= mcand_q << MUL_SLICE;
            mplier_q <= mplier_q >> MUL_SLICE;
            if (step_q == MUL_CYCLES - 1) begin
                result_o <= acc_next;   // low word of the product
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/commit_unit.sv ====
`default_nettype none

module commit_unit (
    input  logic                          clk_i,
    input  logic                          rst_n,
    input  logic                          head_valid_i,
    input  logic [core_pkg::REG_BITS-1:0] head_rd_i,
    input  logic                          head_we_i,
    input  logic [core_pkg::XLEN-1:0]     head_data_i,
    input  logic                          head_halt_i,
    output logic                          commit_ack_o,
    input  logic [core_pkg::REG_BITS-1:0] raddr_a_i,
    input  logic [core_pkg::REG_BITS-1:0] raddr_b_i,
    output logic [core_pkg::XLEN-1:0]     rdata_a_o,
    output logic [core_pkg::XLEN-1:0]     rdata_b_o,
    output logic                          retire_valid_o,
    output logic [core_pkg::REG_BITS-1:0] retire_rd_o,
    output logic [core_pkg::XLEN-1:0]     retire_data_o,
    output logic                          retire_we_o,
    output logic                          halted_o
);
    import core_pkg::*;

    logic [XLEN-1:0] rf_q [NR_REGS];
    logic            rf_we;
    logic            halt_retired_q;

    assign commit_ack_o = head_valid_i;   // head is never refused
    assign rf_we        = head_valid_i && head_we_i && (head_rd_i != '0);
    assign rdata_a_o    = rf_q[raddr_a_i];
    assign rdata_b_o    = rf_q[raddr_b_i];

    // r0 is cleared at reset and never written
    always_ff @(posedge clk_i or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NR_REGS; i++) begin
                rf_q[i] <= '0;
            end
        end else if (rf_we) begin
            rf_q[head_rd_i] <= head_data_i;
        end
    end

    always_ff @(posedge clk_i or negedge rst_n) begin
        if (!rst_n) begin
            retire_valid_o <= 1'b0;
            halt_retired_q <= 1'b0;
            halted_o       <= 1'b0;
        end else begin
            retire_valid_o <= head_valid_i;
            halt_retired_q <= head_valid_i && head_halt_i;
            halted_o       <= halted_o || halt_retired_q;   // sticky until reset
        end
    end

    always_ff @(posedge clk_i) begin
        if (head_valid_i) begin
            retire_rd_o   <= head_rd_i;
            retire_data_o <= head_data_i;
            retire_we_o   <= rf_we;
        end
    end

endmodule

`default_nettype wire

// ==== design/mini_core.sv ====
`default_nettype none

module mini_core (
    input  logic                          clk_i,
    input  logic                          rst_n,
    input  logic                          fetch_enable_i,
    input  logic [core_pkg::XLEN-1:0]     boot_addr_i,
    output logic                          wb_cyc_o,
    output logic                          wb_stb_o,
    output logic [core_pkg::XLEN-1:0]     wb_adr_o,
    input  logic [core_pkg::XLEN-1:0]     wb_dat_i,
    input  logic                          wb_ack_i,
    output logic                          retire_valid_o,
    output logic [core_pkg::REG_BITS-1:0] retire_rd_o,
    output logic [core_pkg::XLEN-1:0]     retire_data_o,
    output logic                          retire_we_o,
    output logic                          halted_o,
    output logic                          core_busy_o
);
    import core_pkg::*;

    logic                                   fetch_enable_q;
    logic                                   instr_valid;
    logic [XLEN-1:0]                        instr_data;
    logic                                   instr_ready;
    logic                                   halt_req;
    logic [REG_BITS-1:0]                    raddr_a;
    logic [REG_BITS-1:0]                    raddr_b;
    logic [XLEN-1:0]                        rdata_a;
    logic [XLEN-1:0]                        rdata_b;
    logic [NR_LANES-1:0]                    lane_valid;
    op_e  [NR_LANES-1:0]                    lane_op;
    logic [NR_LANES-1:0][XLEN-1:0]          lane_a;
    logic [NR_LANES-1:0][XLEN-1:0]          lane_b;
    logic [NR_LANES-1:0][TRANS_ID_BITS-1:0] lane_id;
    logic [NR_LANES-1:0]                    lane_ready;
    logic [NR_LANES-1:0]                    lane_done;
    logic [NR_LANES-1:0][XLEN-1:0]          lane_result;
    logic [NR_LANES-1:0][TRANS_ID_BITS-1:0] lane_done_id;
    logic                                   head_valid;
    logic [REG_BITS-1:0]                    head_rd;
    logic                                   head_we;
    logic [XLEN-1:0]                        head_data;
    logic                                   head_halt;
    logic                                   commit_ack;
    logic                                   sb_busy;

    assign core_busy_o = (fetch_enable_q && !halted_o) || sb_busy;

    // enable is sampled once at the core boundary
    always_ff @(posedge clk_i or negedge rst_n) begin
        if (!rst_n) begin
            fetch_enable_q <= 1'b0;
        end else begin
            fetch_enable_q <= fetch_enable_i;
        end
    end

    fetch_unit u_fetch_unit (
        .enable_i      (fetch_enable_q),
        .halt_i        (halt_req),
        .instr_valid_o (instr_valid),
        .instr_data_o  (instr_data),
        .instr_ready_i (instr_ready),
        .*
    );

    issue_stage u_issue_stage (
        .clk_i          (clk_i),
        .rst_n          (rst_n),
        .instr_valid_i  (instr_valid),
        .instr_data_i   (instr_data),
        .instr_ready_o  (instr_ready),
        .halt_o         (halt_req),
        .raddr_a_o      (raddr_a),
        .raddr_b_o      (raddr_b),
        .rdata_a_i      (rdata_a),
        .rdata_b_i      (rdata_b),
        .lane_valid_o   (lane_valid),
        .lane_op_o      (lane_op),
        .lane_a_o       (lane_a),
        .lane_b_o       (lane_b),
        .lane_id_o      (lane_id),
        .lane_ready_i   (lane_ready),
        .lane_done_i    (lane_done),
        .lane_result_i  (lane_result),
        .lane_done_id_i (lane_done_id),
        .head_valid_o   (head_valid),
        .head_rd_o      (head_rd),
        .head_we_o      (head_we),
        .head_data_o    (head_data),
        .head_halt_o    (head_halt),
        .commit_ack_i   (commit_ack),
        .busy_o         (sb_busy)
    );

    for (genvar k = 0; k < NR_LANES; k++) begin : g_lane
        alu_lane u_alu_lane (
            .clk_i     (clk_i),
            .rst_n     (rst_n),
            .valid_i   (lane_valid[k]),
            .op_i      (lane_op[k]),
            .a_i       (lane_a[k]),
            .b_i       (lane_b[k]),
            .id_i      (lane_id[k]),
            .ready_o   (lane_ready[k]),
            .done_o    (lane_done[k]),
            .result_o  (lane_result[k]),
            .done_id_o (lane_done_id[k])
        );
    end

    commit_unit u_commit_unit (
        .head_valid_i (head_valid),
        .head_rd_i    (head_rd),
        .head_we_i    (head_we),
        .head_data_i  (head_data),
        .head_halt_i  (head_halt),
        .commit_ack_o (commit_ack),
        .raddr_a_i    (raddr_a),
        .raddr_b_i    (raddr_b),
        .rdata_a_o    (rdata_a),
        .rdata_b_o    (rdata_b),
        .*
    );

endmodule

`default_nettype wire

// ==== bench/mini_core_asserts.sv ====
`default_nettype none

module mini_core_asserts (
    input logic                      clk_i,
    input logic                      rst_n,
    input logic                      wb_cyc_o,
    input logic                      wb_stb_o,
    input logic [core_pkg::XLEN-1:0] wb_adr_o,
    input logic                      wb_ack_i,
    input logic                      retire_valid_o,
    input logic                      halted_o
);

    a_stb_in_cyc: assert property (@(posedge clk_i) disable iff (!rst_n)
        wb_stb_o |-> wb_cyc_o)
        else $error("wb_stb_o high outside a bus cycle");

    // classic cycle: request held until the slave acks
    a_adr_stable: assert property (@(posedge clk_i) disable iff (!rst_n)
        (wb_stb_o && !wb_ack_i) |=> (wb_stb_o && $stable(wb_adr_o)))
        else $error("wb_adr_o or wb_stb_o changed while waiting for ack");

    a_no_retire_halted: assert property (@(posedge clk_i) disable iff (!rst_n)
        halted_o |-> !retire_valid_o)
        else $error("instruction retired while halted");

endmodule

bind mini_core mini_core_asserts u_mini_core_asserts (.*);

`default_nettype wire

// ==== bench/tb_mini_core.sv ====
`default_nettype none

module tb_mini_core;
    import core_pkg::*;

    localparam int          CLK_PERIOD       = 100;
    localparam int          DRIVE_DELAY      = 10;
    localparam int          RESET_CYCLES     = 8;
    localparam int          MEM_WORDS        = 256;
    localparam int          ADR_BITS         = 8;
    localparam logic [31:0] BOOT_ADDR        = 32'h10;
    localparam logic [31:0] LFSR_SEED        = 32'h9e95;
    localparam logic [31:0] LFSR_TAPS        = 32'h8020_0003;
    localparam int          WAIT_BITS        = 2;
    localparam int          TOTAL_INSTR      = 53;   // words over all loaded programs
    localparam int          NR_RUNS          = 6;
    localparam int          CYCLES_PER_INSTR = 30;
    localparam int          SETTLE_CYCLES    = 40;
    localparam int          WATCHDOG_TIME    = (TOTAL_INSTR * CYCLES_PER_INSTR
                                               + NR_RUNS * (RESET_CYCLES + SETTLE_CYCLES))
                                               * CLK_PERIOD;

    typedef struct packed {
        logic [REG_BITS-1:0] rd;
        logic                we;
        logic [XLEN-1:0]     data;
    } retire_t;

    logic                clk_i;
    logic                rst_n;
    logic                fetch_enable_i;
    logic [XLEN-1:0]     boot_addr_i;
    logic                wb_cyc_o;
    logic                wb_stb_o;
    logic [XLEN-1:0]     wb_adr_o;
    logic [XLEN-1:0]     wb_dat_i;
    logic                wb_ack_i;
    logic                retire_valid_o;
    logic [REG_BITS-1:0] retire_rd_o;
    logic [XLEN-1:0]     retire_data_o;
    logic                retire_we_o;
    logic                halted_o;
    logic                core_busy_o;

    logic [XLEN-1:0]     mem [MEM_WORDS];
    logic [XLEN-1:0]     prog_q [$];
    retire_t             exp_q [$];
    retire_t             exp_item;
    logic [31:0]         lfsr_q;
    bit                  use_waits;

    mini_core u_mini_core (.*);

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    task automatic stop_run(input string line);
        $display("%s", line);
        $display("Checks failed");
        $fatal(1, "simulation stopped on the first error");
    endtask

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
    endfunction

    // one lfsr step per bit, at least one wait state per access
    function automatic int draw_waits();
        int n;
        n = 0;
        for (int i = 0; i < WAIT_BITS; i++) begin
            lfsr_q = lfsr_step(lfsr_q);
            n = (n << 1) | int'(lfsr_q[0]);
        end
        return n + 1;
    endfunction

    function automatic logic [31:0] enc(input op_e op, input int rd, input int rs1,
                                        input int rs2, input int imm);
        return {op, rd[3:0], rs1[3:0], rs2[3:0], imm[15:0]};
    endfunction

    // wishbone slave, registered ack
    initial begin
        bit in_req;
        int wait_left;
        wb_ack_i  = 1'b0;
        wb_dat_i  = '0;
        in_req    = 1'b0;
        wait_left = 0;
        forever begin
            @(posedge clk_i);
            #DRIVE_DELAY;
            if (!rst_n || wb_ack_i) begin
                wb_ack_i = 1'b0;
                in_req   = 1'b0;
            end else if (wb_cyc_o && wb_stb_o) begin
                if (!in_req) begin
                    in_req    = 1'b1;
                    wait_left = use_waits ? draw_waits() : 0;
                end
                if (wait_left == 0) begin
                    assert (wb_adr_o < MEM_WORDS)
                    else stop_run("fetch address is outside the program memory");
                    wb_dat_i = mem[wb_adr_o[ADR_BITS-1:0]];
                    wb_ack_i = 1'b1;
                end else begin
                    wait_left--;
                end
            end
        end
    end

    // retire monitor, sampled mid-cycle
    always @(negedge clk_i) begin
        if (rst_n && retire_valid_o) begin
            if (exp_q.size() == 0) begin
                stop_run("an instruction retired after the last expected one");
            end else begin
                exp_item = exp_q.pop_front();
                assert (retire_rd_o == exp_item.rd && retire_we_o == exp_item.we
                        && retire_data_o == exp_item.data)
                else stop_run($sformatf(
                    "MISMATCH at %0t: retire rd=%0d we=%b data=%h, expected rd=%0d we=%b data=%h",
                    $time, retire_rd_o, retire_we_o, retire_data_o,
                    exp_item.rd, exp_item.we, exp_item.data));
            end
        end
    end

    initial begin
        #(WATCHDOG_TIME);
        stop_run("watchdog expired before the tests finished");
    end

    task automatic load_program();
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = 32'hF000_0000 | (32'(i) * 32'h0001_0101);   // opcode F never runs
        end
        for (int j = 0; j < prog_q.size(); j++) begin
            mem[BOOT_ADDR + j] = prog_q[j];
        end
    endtask

    // sequential model of the program, stops at HALT
    task automatic build_expected();
        logic [XLEN-1:0] regs [NR_REGS];
        logic [XLEN-1:0] word;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] imm;
        logic [XLEN-1:0] res;
        logic [XLEN-1:0] pc;
        logic            writes;
        bit              done;
        retire_t         item;
        for (int i = 0; i < NR_REGS; i++) begin
            regs[i] = '0;
        end
        exp_q.delete();
        pc   = BOOT_ADDR;
        done = 1'b0;
        for (int steps = 0; steps < MEM_WORDS && !done; steps++) begin
            word   = mem[pc[ADR_BITS-1:0]];
            a      = regs[word[23:20]];
            b      = regs[word[19:16]];
            imm    = {{16{word[15]}}, word[15:0]};
            writes = 1'b1;
            case (word[31:28])
                OP_ADD:  res = a + b;
                OP_SUB:  res = a - b;
                OP_AND:  res = a & b;
                OP_OR:   res = a | b;
                OP_XOR:  res = a ^ b;
                OP_ADDI: res = a + imm;
                OP_MUL:  res = a * b;
                OP_HALT: begin
                    res    = '0;
                    writes = 1'b0;
                    done   = 1'b1;
                end
                default: begin
                    res    = '0;
                    writes = 1'b0;
                end
            endcase
            item.rd   = word[27:24];
            item.we   = writes && (word[27:24] != 4'd0);
            item.data = res;
            exp_q.push_back(item);
            if (item.we) begin
                regs[word[27:24]] = res;
            end
            pc = pc + 32'd1;
        end
    endtask

    task automatic apply_reset();
        @(posedge clk_i);
        #DRIVE_DELAY;
        rst_n          = 1'b0;
        fetch_enable_i = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_i);
        #DRIVE_DELAY;
        rst_n = 1'b1;
    endtask

    task automatic check_idle();
        repeat (3) begin
            @(posedge clk_i);
            #DRIVE_DELAY;
            assert (!wb_cyc_o && !wb_stb_o && !retire_valid_o && !halted_o && !core_busy_o)
            else stop_run($sformatf(
                "MISMATCH at %0t: not idle after reset cyc=%b stb=%b retire=%b halt=%b busy=%b",
                $time, wb_cyc_o, wb_stb_o, retire_valid_o, halted_o, core_busy_o));
        end
    endtask

    task automatic run_program(input bit waits);
        int limit;
        int cycles;
        limit  = prog_q.size() * CYCLES_PER_INSTR;
        cycles = 0;
        load_program();
        build_expected();
        use_waits = waits;
        apply_reset();
        check_idle();
        boot_addr_i    = BOOT_ADDR;
        fetch_enable_i = 1'b1;
        while (!halted_o && cycles < limit) begin
            @(posedge clk_i);
            #DRIVE_DELAY;
            cycles++;
            // enable is registered, so busy holds from the next cycle until halt
            assert (halted_o || core_busy_o)
            else stop_run($sformatf("MISMATCH at %0t: core_busy_o low while the core runs",
                                    $time));
        end
        assert (halted_o) else stop_run("halted_o did not rise within the cycle limit");
        assert (exp_q.size() == 0)
        else stop_run($sformatf("%0d expected instructions never retired", exp_q.size()));
        // halt is sticky, the bus stays quiet and the scoreboard drained
        repeat (12) begin
            @(posedge clk_i);
            #DRIVE_DELAY;
            assert (halted_o && !wb_cyc_o && !wb_stb_o && !core_busy_o)
            else stop_run($sformatf("MISMATCH at %0t: after halt halt=%b cyc=%b stb=%b busy=%b",
                                    $time, halted_o, wb_cyc_o, wb_stb_o, core_busy_o));
        end
        fetch_enable_i = 1'b0;
    endtask

    task automatic test_reset_idle();
        apply_reset();
        check_idle();
    endtask

    task automatic test_independent_alu();
        prog_q = '{enc(OP_ADDI, 1, 0, 0, 1234), enc(OP_ADDI, 2, 0, 0, -77),
                   enc(OP_ADDI, 3, 0, 0, 16'h5a5a), enc(OP_ADDI, 4, 0, 0, 16'h0ff0),
                   enc(OP_ADD, 5, 1, 2, 0), enc(OP_SUB, 6, 3, 4, 0),
                   enc(OP_AND, 7, 3, 4, 0), enc(OP_OR, 8, 1, 3, 0),
                   enc(OP_XOR, 9, 2, 4, 0), enc(OP_ADDI, 0, 1, 0, 5),
                   enc(OP_HALT, 0, 0, 0, 0)};
        run_program(1'b0);
    endtask

    task automatic test_dependency_chain();
        prog_q = '{enc(OP_ADDI, 1, 0, 0, 3), enc(OP_ADD, 2, 1, 1, 0),
                   enc(OP_SUB, 3, 2, 1, 0), enc(OP_XOR, 4, 3, 2, 0),
                   enc(OP_ADDI, 5, 4, 0, -1000), enc(OP_MUL, 6, 5, 5, 0),
                   enc(OP_OR, 7, 6, 1, 0), enc(OP_AND, 8, 7, 6, 0),
                   enc(OP_HALT, 0, 0, 0, 0)};
        run_program(1'b0);
    endtask

    // later single-cycle ops finish before the multiply
    task automatic test_mul_reorder();
        prog_q = '{enc(OP_ADDI, 1, 0, 0, 16'h1234), enc(OP_ADDI, 2, 0, 0, -3),
                   enc(OP_ADDI, 3, 0, 0, 16'h7fff), enc(OP_MUL, 4, 1, 2, 0),
                   enc(OP_ADDI, 5, 0, 0, 11), enc(OP_ADDI, 6, 3, 0, 1),
                   enc(OP_XOR, 7, 3, 0, 0), enc(OP_MUL, 8, 3, 3, 0),
                   enc(OP_ADD, 9, 5, 6, 0), enc(OP_HALT, 0, 0, 0, 0)};
        run_program(1'b0);
    endtask

    task automatic test_wait_states();
        prog_q = '{enc(OP_ADDI, 1, 0, 0, -1), enc(OP_ADDI, 2, 0, 0, 16'h0101),
                   enc(OP_MUL, 3, 1, 2, 0), enc(OP_ADD, 4, 2, 2, 0),
                   enc(OP_SUB, 5, 0, 2, 0), 32'h8321_0000,
                   enc(OP_MUL, 6, 4, 2, 0), enc(OP_XOR, 7, 6, 3, 0),
                   enc(OP_HALT, 0, 0, 0, 0)};
        run_program(1'b0);
        run_program(1'b1);
    endtask

    task automatic test_halt();
        prog_q = '{enc(OP_ADDI, 1, 0, 0, 42), enc(OP_ADDI, 2, 1, 0, 1),
                   enc(OP_HALT, 0, 0, 0, 0), enc(OP_ADDI, 3, 0, 0, 99),
                   enc(OP_ADDI, 1, 0, 0, 0)};
        run_program(1'b1);
    endtask

    initial begin
        rst_n          = 1'b0;
        fetch_enable_i = 1'b0;
        boot_addr_i    = BOOT_ADDR;
        lfsr_q         = LFSR_SEED;
        use_waits      = 1'b0;
        test_reset_idle();
        test_independent_alu();
        test_dependency_chain();
        test_mul_reorder();
        test_wait_states();
        test_halt();
        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
design/core_pkg.sv
design/fetch_unit.sv
design/issue_stage.sv
design/alu_lane.sv
design/commit_unit.sv
design/mini_core.sv
bench/mini_core_asserts.sv
bench/tb_mini_core.sv

// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert -Wno-fatal -f vlog.f \
		--top-module tb_mini_core -Mdir obj_dir
	./obj_dir/Vtb_mini_core

clean:
	rm -rf obj_dir
